// File: hdl/ex_pkg.sv
package ex_pkg;

    // data and register index widths
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    // low half used by the word forms (addw, sllw, mulw ...)
    localparam int WORD_W = 32;

    // one multiplier bit per iteration
    localparam int MUL_CYCLES = 64;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

    // branch condition codes, straight from funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef logic [XLEN-1:0]       xword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // which unit produces the result
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_MUL
    } ex_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // decoded operation as it leaves decode
    typedef struct packed {
        xword_t    pc;
        ex_class_e op_class;
        alu_op_e   alu_op;
        logic [2:0] funct3;
        logic      use_imm;
        logic      word;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_rs2;
        xword_t    imm;
    } ex_uop_t;

    // operation plus register file reads
    typedef struct packed {
        ex_uop_t uop;
        xword_t  src_a;
        xword_t  src_b;
    } ex_issue_t;

    // write port of a later stage, seen for bypass
    typedef struct packed {
        logic      wen;
        reg_addr_t rd;
        xword_t    data;
    } fwd_bus_t;

    typedef struct packed {
        xword_t    pc;
        reg_addr_t rd;
        xword_t    result;
    } ex_result_t;

    typedef struct packed {
        logic   valid;
        xword_t target;
    } redirect_t;

endpackage

// File: hdl/ex_issue_reg.sv
module ex_issue_reg import ex_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      advance,
    input  ex_issue_t in,
    input  fwd_bus_t  mem_fwd,
    input  fwd_bus_t  wb_fwd,
    output logic      op_valid,
    output ex_uop_t   uop,
    output xword_t    opnd_a,
    output xword_t    opnd_b
);

    // held operation and its register file values
    ex_issue_t issue_q;

    // bypass pick for one source
    // mem stage is younger than wb, so it wins
    function automatic xword_t fwd_pick(
        input reg_addr_t idx,
        input logic      en,
        input xword_t    reg_val,
        input fwd_bus_t  mem_b,
        input fwd_bus_t  wb_b
    );
        logic hit_mem;
        logic hit_wb;
        // x0 reads as zero and is never bypassed
        hit_mem = en && mem_b.wen && (mem_b.rd == idx) && (idx != '0);
        hit_wb  = en && wb_b.wen && (wb_b.rd == idx) && (idx != '0);
        if (hit_mem) begin
            return mem_b.data;
        end
        if (hit_wb) begin
            return wb_b.data;
        end
        return reg_val;
    endfunction

    // flush beats a stall on the valid bit
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            op_valid <= 1'b0;
        end else if (advance) begin
            op_valid <= 1'b1;
        end
    end

    // payload only moves on advance
    always_ff @(posedge clk) begin
        if (advance) begin
            issue_q <= in;
        end
    end

    assign uop = issue_q.uop;

    // bypass is looked at every cycle the op sits here,
    // so a producer reaching mem/wb late is still caught
    always_comb begin
        opnd_a = fwd_pick(issue_q.uop.rs1, 1'b1, issue_q.src_a, mem_fwd, wb_fwd);
        opnd_b = fwd_pick(issue_q.uop.rs2, issue_q.uop.use_rs2, issue_q.src_b,
                          mem_fwd, wb_fwd);
    end

endmodule

// File: hdl/ex_alu.sv
module ex_alu import ex_pkg::*; (
    input  ex_uop_t uop,
    input  xword_t  opnd_a,
    input  xword_t  opnd_b,
    output xword_t  alu_result
);

    xword_t              b_val;
    xword_t              res_full;
    logic [WORD_W-1:0]   a_lo;
    logic [WORD_W-1:0]   b_lo;
    logic [WORD_W-1:0]   res_lo;
    logic [5:0]          shamt;
    logic [4:0]          shamt_w;

    // immediate forms take b from imm
    assign b_val = uop.use_imm ? uop.imm : opnd_b;

    assign shamt   = b_val[5:0];
    // word shifts only look at 5 bits
    assign shamt_w = b_val[4:0];
    assign a_lo    = opnd_a[WORD_W-1:0];
    assign b_lo    = b_val[WORD_W-1:0];

    // full 64-bit forms
    always_comb begin
        case (uop.alu_op)
            ALU_ADD:  res_full = opnd_a + b_val;
            ALU_SUB:  res_full = opnd_a - b_val;
            ALU_SLL:  res_full = opnd_a << shamt;
            ALU_SLT:  res_full = {{(XLEN-1){1'b0}}, $signed(opnd_a) < $signed(b_val)};
            ALU_SLTU: res_full = {{(XLEN-1){1'b0}}, opnd_a < b_val};
            ALU_XOR:  res_full = opnd_a ^ b_val;
            ALU_SRL:  res_full = opnd_a >> shamt;
            ALU_SRA:  res_full = xword_t'($signed(opnd_a) >>> shamt);
            ALU_OR:   res_full = opnd_a | b_val;
            ALU_AND:  res_full = opnd_a & b_val;
            default:  res_full = '0;
        endcase
    end

    // word forms on the low half only
    // srl/sra must not see the upper bits of a
    always_comb begin
        case (uop.alu_op)
            ALU_ADD:  res_lo = a_lo + b_lo;
            ALU_SUB:  res_lo = a_lo - b_lo;
            ALU_SLL:  res_lo = a_lo << shamt_w;
            ALU_SLT:  res_lo = {{(WORD_W-1){1'b0}}, $signed(a_lo) < $signed(b_lo)};
            ALU_SLTU: res_lo = {{(WORD_W-1){1'b0}}, a_lo < b_lo};
            ALU_XOR:  res_lo = a_lo ^ b_lo;
            ALU_SRL:  res_lo = a_lo >> shamt_w;
            ALU_SRA:  res_lo = WORD_W'($signed(a_lo) >>> shamt_w);
            ALU_OR:   res_lo = a_lo | b_lo;
            ALU_AND:  res_lo = a_lo & b_lo;
            default:  res_lo = '0;
        endcase
    end

    // word results sign-extend from bit 31
    assign alu_result = uop.word ? {{(XLEN-WORD_W){res_lo[WORD_W-1]}}, res_lo}
                                 : res_full;

endmodule

// File: hdl/ex_branch_unit.sv
module ex_branch_unit import ex_pkg::*; (
    input  logic    op_valid,
    input  ex_uop_t uop,
    input  xword_t  opnd_a,
    input  xword_t  opnd_b,
    output logic    taken,
    output xword_t  target,
    output xword_t  link
);

    logic   cond;
    logic   is_branch;
    logic   is_jal;
    logic   is_jalr;
    xword_t jalr_sum;

    assign is_branch = (uop.op_class == CLS_BRANCH);
    assign is_jal    = (uop.op_class == CLS_JAL);
    assign is_jalr   = (uop.op_class == CLS_JALR);

    // compare on the bypassed operands
    always_comb begin
        case (uop.funct3)
            F3_BEQ:  cond = (opnd_a == opnd_b);
            F3_BNE:  cond = (opnd_a != opnd_b);
            F3_BLT:  cond = ($signed(opnd_a) < $signed(opnd_b));
            F3_BGE:  cond = ($signed(opnd_a) >= $signed(opnd_b));
            F3_BLTU: cond = (opnd_a < opnd_b);
            F3_BGEU: cond = (opnd_a >= opnd_b);
            // funct3 2 and 3 are not branches
            default: cond = 1'b0;
        endcase
    end

    // jalr is register relative, lsb dropped
    assign jalr_sum = opnd_a + uop.imm;

    // branch and jal are pc relative
    assign target = is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : (uop.pc + uop.imm);

    // return address for jal/jalr
    assign link = uop.pc + xword_t'(4);

    // no prediction here, every taken transfer redirects
    assign taken = op_valid && (is_jal || is_jalr || (is_branch && cond));

endmodule

// File: hdl/ex_multiplier.sv
module ex_multiplier import ex_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  logic   ack,
    input  logic   word,
    input  xword_t multiplicand,
    input  xword_t multiplier,
    output logic   busy,
    output logic   done,
    output xword_t product
);

    logic                 idle;
    logic [MUL_CNT_W-1:0] cnt;
    xword_t               acc;
    xword_t               mcand;
    xword_t               mplier;
    logic                 word_q;

    assign idle = !busy && !done;

    // busy for MUL_CYCLES edges, then done until acked
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (start && idle) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            // last iteration lands together with done
            if (cnt == MUL_CNT_W'(MUL_CYCLES - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (done && ack) begin
            done <= 1'b0;
        end
    end

    // shift-add datapath, one multiplier bit per edge
    always_ff @(posedge clk) begin
        if (start && idle) begin
            acc    <= '0;
            mcand  <= multiplicand;
            mplier <= multiplier;
            word_q <= word;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // bits shifted past XLEN are the high half, not kept
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // mulw keeps the low word, sign-extended
    assign product = word_q ? {{(XLEN-WORD_W){acc[WORD_W-1]}}, acc[WORD_W-1:0]} : acc;

    // the stage must wait for idle before a new start
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (reset)
        start |-> !busy
    );

    // result held for the output handshake
    a_done_hold: assert property (
        @(posedge clk) disable iff (reset)
        done && !ack |=> done && $stable(product)
    );

endmodule

// File: hdl/ex_result_select.sv
module ex_result_select import ex_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       op_valid,
    input  ex_uop_t    uop,
    input  xword_t     alu_result,
    input  xword_t     link,
    input  xword_t     product,
    input  logic       busy,
    input  logic       done,
    input  logic       taken,
    input  xword_t     target,
    input  logic       out_ready,
    output logic       mul_start,
    output logic       mul_ack,
    output logic       advance,
    output logic       in_ready,
    output logic       out_valid,
    output ex_result_t out,
    output redirect_t  redirect
);

    logic is_mul;
    logic is_jump;
    logic mul_wait;
    logic out_fire;

    assign is_mul  = (uop.op_class == CLS_MUL);
    assign is_jump = (uop.op_class == CLS_JAL) || (uop.op_class == CLS_JALR);

    // a mul in the slot blocks the stage until done
    assign mul_wait = op_valid && is_mul && !done;

    // kick the multiplier once per mul op
    assign mul_start = op_valid && is_mul && !busy && !done;

    assign out_valid = op_valid && !mul_wait;
    assign out_fire  = out_valid && out_ready;

    // done is released on the transfer to memory
    assign mul_ack = out_fire && is_mul;

    // decode moves only when memory takes our result
    assign in_ready = !mul_wait && out_ready;
    assign advance  = in_ready;

    always_comb begin
        out.pc = uop.pc;
        out.rd = uop.rd;
        if (is_jump) begin
            out.result = link;
        end else if (is_mul) begin
            out.result = product;
        end else begin
            out.result = alu_result;
        end
    end

    // fetch is redirected once, on the transfer edge
    assign redirect.valid  = taken && out_fire;
    assign redirect.target = target;

    // held result must not change under back-pressure
    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out.result) || !out_valid
    );

endmodule

// File: hdl/ex_stage.sv
module ex_stage import ex_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       in_valid,
    input  ex_issue_t  in,
    output logic       in_ready,
    input  logic       out_ready,
    input  fwd_bus_t   mem_fwd,
    input  fwd_bus_t   wb_fwd,
    output logic       out_valid,
    output ex_result_t out,
    output redirect_t  redirect
);

    logic    op_valid;
    ex_uop_t uop;
    xword_t  opnd_a;
    xword_t  opnd_b;
    xword_t  alu_result;
    logic    taken;
    xword_t  target;
    xword_t  link;
    logic    mul_start;
    logic    mul_ack;
    logic    mul_busy;
    logic    mul_done;
    xword_t  product;
    logic    advance;
    logic    issue_load;
    logic    issue_clear;
    logic    mul_reset;

    // advance with no new op leaves a bubble behind
    assign issue_load  = advance && in_valid;
    assign issue_clear = flush || (advance && !in_valid);

    // flush also drops a multiply in flight
    assign mul_reset = reset || flush;

    ex_issue_reg u_issue (
        .clk      (clk),
        .reset    (reset),
        .flush    (issue_clear),
        .advance  (issue_load),
        .in       (in),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb_fwd),
        .op_valid (op_valid),
        .uop      (uop),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b)
    );

    ex_alu u_alu (
        .uop        (uop),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .alu_result (alu_result)
    );

    ex_branch_unit u_branch (
        .op_valid (op_valid),
        .uop      (uop),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b),
        .taken    (taken),
        .target   (target),
        .link     (link)
    );

    ex_multiplier u_mul (
        .clk          (clk),
        .reset        (mul_reset),
        .start        (mul_start),
        .ack          (mul_ack),
        .word         (uop.word),
        .multiplicand (opnd_a),
        .multiplier   (opnd_b),
        .busy         (mul_busy),
        .done         (mul_done),
        .product      (product)
    );

    ex_result_select u_select (
        .clk        (clk),
        .reset      (reset),
        .op_valid   (op_valid),
        .uop        (uop),
        .alu_result (alu_result),
        .link       (link),
        .product    (product),
        .busy       (mul_busy),
        .done       (mul_done),
        .taken      (taken),
        .target     (target),
        .out_ready  (out_ready),
        .mul_start  (mul_start),
        .mul_ack    (mul_ack),
        .advance    (advance),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out        (out),
        .redirect   (redirect)
    );

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: test/tb_ex_stage.sv
module tb_ex_stage import ex_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          N_OPS     = 400;
    localparam int          WD_CYCLES = N_OPS * (MUL_CYCLES + 4) + 50;
    localparam logic [31:0] SEED      = 32'hb6e9_5aab;

    // what the stage must hand to memory for one accepted op
    typedef struct packed {
        ex_result_t res;
        logic       taken;
        xword_t     target;
        logic       is_mul;
    } golden_t;

    logic       clk;
    logic       reset;
    logic       flush     = 1'b0;
    logic       in_valid  = 1'b0;
    ex_issue_t  in        = '0;
    logic       out_ready = 1'b0;
    fwd_bus_t   mem_fwd   = '0;
    fwd_bus_t   wb_fwd    = '0;
    logic       in_ready;
    logic       out_valid;
    ex_result_t out;
    redirect_t  redirect;

    logic [31:0] lfsr = SEED;
    golden_t     exp_q[$];
    golden_t     exp_head = '0;
    logic        have_exp = 1'b0;
    logic        drained  = 1'b0;
    int          mul_wait = 0;
    int          errors      = 0;
    int          n_accepted  = 0;
    int          n_results   = 0;
    int          n_flushed   = 0;

    tb_clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    ex_stage dut0 (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in        (in),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .out_valid (out_valid),
        .out       (out),
        .redirect  (redirect)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic xword_t take_bits(input int n);
        xword_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic xword_t sext_word(input xword_t v);
        return {{32{v[31]}}, v[31:0]};
    endfunction

    // mem wins over wb and x0 is never bypassed
    function automatic xword_t bypass_operand(input reg_addr_t idx, input logic en,
                                              input xword_t regv, input fwd_bus_t m,
                                              input fwd_bus_t w);
        if (!en || idx == '0) begin
            return regv;
        end
        if (m.wen && m.rd == idx) begin
            return m.data;
        end
        if (w.wen && w.rd == idx) begin
            return w.data;
        end
        return regv;
    endfunction

    // one datapath for both widths with operands masked to the active width
    function automatic xword_t alu_model(input alu_op_e op, input xword_t a,
                                         input xword_t b, input logic word);
        xword_t mask;
        xword_t msb;
        xword_t x;
        xword_t y;
        xword_t r;
        int     sh;
        mask = word ? 64'h0000_0000_ffff_ffff : '1;
        msb  = word ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
        x    = a & mask;
        y    = b & mask;
        sh   = word ? int'(b[4:0]) : int'(b[5:0]);
        case (op)
            ALU_ADD:  r = x + y;
            ALU_SUB:  r = x - y;
            ALU_SLL:  r = x << sh;
            // signed compare by flipping the sign bit
            ALU_SLT:  r = xword_t'((x ^ msb) < (y ^ msb));
            ALU_SLTU: r = xword_t'(x < y);
            ALU_XOR:  r = x ^ y;
            ALU_SRL:  r = x >> sh;
            // logical shift, then refill the vacated top bits
            ALU_SRA:  r = (x >> sh) | (((x & msb) != '0) ? (mask & ~(mask >> sh)) : '0);
            ALU_OR:   r = x | y;
            ALU_AND:  r = x & y;
            default:  r = '0;
        endcase
        r = r & mask;
        return word ? sext_word(r) : r;
    endfunction

    function automatic logic cond_model(input logic [2:0] f3, input xword_t a,
                                        input xword_t b);
        logic lt_s;
        lt_s = (a ^ 64'h8000_0000_0000_0000) < (b ^ 64'h8000_0000_0000_0000);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return lt_s;
            3'b101:  return !lt_s;
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // full 128-bit product with the low half kept
    function automatic xword_t mul_model(input xword_t a, input xword_t b, input logic word);
        logic [2*XLEN-1:0] full;
        full = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        return word ? sext_word(full[XLEN-1:0]) : full[XLEN-1:0];
    endfunction

    function automatic golden_t golden_for(input ex_issue_t op, input fwd_bus_t m,
                                           input fwd_bus_t w);
        golden_t g;
        ex_uop_t u;
        xword_t  a;
        xword_t  b;
        xword_t  sum;
        u        = op.uop;
        a        = bypass_operand(u.rs1, 1'b1, op.src_a, m, w);
        b        = bypass_operand(u.rs2, u.use_rs2, op.src_b, m, w);
        sum      = a + u.imm;
        g.res.pc = u.pc;
        g.res.rd = u.rd;
        g.is_mul = (u.op_class == CLS_MUL);
        g.taken  = 1'b0;
        g.target = u.pc + u.imm;
        g.res.result = alu_model(u.alu_op, a, u.use_imm ? u.imm : b, u.word);
        case (u.op_class)
            CLS_JAL: begin
                g.res.result = u.pc + 64'd4;
                g.taken      = 1'b1;
            end
            CLS_JALR: begin
                g.res.result = u.pc + 64'd4;
                g.taken      = 1'b1;
                g.target     = {sum[XLEN-1:1], 1'b0};
            end
            CLS_MUL:    g.res.result = mul_model(a, b, u.word);
            CLS_BRANCH: g.taken = cond_model(u.funct3, a, b);
            default: ;
        endcase
        return g;
    endfunction

    // small register range so bypass hits and x0 show up often
    function automatic ex_issue_t random_op();
        ex_issue_t op;
        logic [2:0] c;
        logic [3:0] k;
        c = 3'(take_bits(3));
        k = 4'(take_bits(4));
        op.uop.op_class = ex_class_e'(c % 3'd5);
        op.uop.alu_op   = alu_op_e'(k % 4'd10);
        op.uop.pc       = take_bits(64) & ~64'h3;
        op.uop.funct3   = 3'(take_bits(3));
        op.uop.use_imm  = take_bits(1) != '0;
        op.uop.word     = take_bits(1) != '0;
        op.uop.rd       = reg_addr_t'(take_bits(5));
        op.uop.rs1      = reg_addr_t'(take_bits(2));
        op.uop.rs2      = reg_addr_t'(take_bits(2));
        op.uop.use_rs2  = take_bits(1) != '0;
        op.uop.imm      = take_bits(64);
        op.src_a        = take_bits(64);
        // equal operands now and then for beq/bge
        op.src_b        = (take_bits(2) == '0) ? op.src_a : take_bits(64);
        return op;
    endfunction

    function automatic fwd_bus_t random_fwd();
        fwd_bus_t f;
        f.wen  = take_bits(1) != '0;
        f.rd   = reg_addr_t'(take_bits(2));
        f.data = take_bits(64);
        return f;
    endfunction

    task automatic value_error(input string name, input xword_t exp, input xword_t got);
        errors++;
        $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    endtask

    task automatic plain_error(input string msg);
        errors++;
        $display("at %0t ns: %s", $time, msg);
    endtask

    task automatic print_summary();
        $display("summary: %0d accepted, %0d results, %0d flushed, %0d errors",
                 n_accepted, n_results, n_flushed, errors);
    endtask

    // stimulus and scoreboard step once per edge
    always @(posedge clk) begin
        fwd_bus_t m_next;
        fwd_bus_t w_next;
        logic     fire_in;
        logic     fire_out;
        if (!reset) begin
            fire_in  = in_valid && in_ready;
            fire_out = out_valid && out_ready;
            if (fire_out && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                n_results++;
            end
            // bypass buses move only when an op is taken
            if (fire_in) begin
                n_accepted++;
                m_next = random_fwd();
                w_next = random_fwd();
                mem_fwd <= m_next;
                wb_fwd  <= w_next;
            end
            // flush drops the held op and the one loaded on this edge
            if (flush) begin
                n_flushed += exp_q.size() + (fire_in ? 1 : 0);
                exp_q.delete();
            end else if (fire_in) begin
                exp_q.push_back(golden_for(in, m_next, w_next));
                mul_wait <= 0;
            end else if (exp_q.size() > 0 && exp_q[0].is_mul && !out_valid) begin
                mul_wait <= mul_wait + 1;
            end
            // decode holds its op until taken
            if (fire_in || !in_valid) begin
                if (n_accepted < N_OPS && take_bits(3) != '0) begin
                    in       <= random_op();
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= take_bits(2) != '0;
            flush     <= take_bits(5) == '0;
            have_exp  <= exp_q.size() > 0;
            if (exp_q.size() > 0) begin
                exp_head <= exp_q[0];
            end
            drained <= (n_accepted >= N_OPS) && (exp_q.size() == 0);
        end
    end

    a_result: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && have_exp |-> out.result == exp_head.res.result)
        else value_error("out.result", $sampled(exp_head.res.result), $sampled(out.result));

    a_pc: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && have_exp |-> out.pc == exp_head.res.pc)
        else value_error("out.pc", $sampled(exp_head.res.pc), $sampled(out.pc));

    a_rd: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && have_exp |-> out.rd == exp_head.res.rd)
        else value_error("out.rd", xword_t'($sampled(exp_head.res.rd)),
                         xword_t'($sampled(out.rd)));

    a_redir_valid: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && have_exp |-> redirect.valid == exp_head.taken)
        else value_error("redirect.valid", xword_t'($sampled(exp_head.taken)),
                         xword_t'($sampled(redirect.valid)));

    a_redir_target: assert property (@(posedge clk) disable iff (reset)
        redirect.valid && have_exp |-> redirect.target == exp_head.target)
        else value_error("redirect.target", $sampled(exp_head.target),
                         $sampled(redirect.target));

    // redirect only on a transfer edge
    a_redir_idle: assert property (@(posedge clk) disable iff (reset)
        !(out_valid && out_ready) |-> !redirect.valid)
        else plain_error("redirect raised without an output transfer");

    // catches flushed or duplicated ops reaching memory
    a_no_extra: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> have_exp)
        else plain_error("output valid with no accepted operation pending");

    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out))
        else plain_error("output dropped or changed under back-pressure");

    a_mul_blocks: assert property (@(posedge clk) disable iff (reset)
        have_exp && exp_head.is_mul && !out_valid |-> !in_ready)
        else plain_error("input ready while a multiply is still running");

    // a finished multiply waits on memory like any other op
    a_ready_follows: assert property (@(posedge clk) disable iff (reset)
        !(have_exp && exp_head.is_mul && !out_valid) |-> in_ready == out_ready)
        else plain_error("input ready differs from output ready with no multiply running");

    a_mul_latency: assert property (@(posedge clk) disable iff (reset)
        mul_wait <= MUL_CYCLES + 2)
        else plain_error("multiply result later than the allowed latency");

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !out_valid && !redirect.valid)
        else plain_error("output or redirect valid right after reset");

    initial begin
        wait (drained);
        repeat (4) @(posedge clk);
        print_summary();
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog sized for every op being a multiply
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        errors++;
        $display("timeout: stage did not drain within %0d cycles", WD_CYCLES);
        print_summary();
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: list.f
hdl/ex_pkg.sv
hdl/ex_issue_reg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_multiplier.sv
hdl/ex_result_select.sv
hdl/ex_stage.sv
test/tb_clock_gen.sv
test/tb_ex_stage.sv
